//--- flist.f
source/core_csr_pkg.sv
source/core_ctrl_pkg.sv
source/int_controller.sv
source/cs_registers.sv
source/controller_fsm.sv
source/cycle_counter.sv
source/core_ctrl.sv
verification/core_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator and run the core_ctrl testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module core_ctrl_tb -f flist.f -o core_ctrl_tb

out=$(./obj_dir/core_ctrl_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Simulation PASSED"; then
  exit 0
fi
exit 1

//--- source/controller_fsm.sv
// Controller FSM for boot, run, sleep and debug halt with interrupt acknowledge
`timescale 1ns/10ps

module controller_fsm (
  input  logic clk_i,
  input  logic rst_i,

  input  logic fetch_enable_i,

  // From interrupt controller
  input  logic irq_req_i,
  input  logic irq_wu_i,

  // Debug and pipeline events
  input  logic debug_req_i,
  input  logic wfi_i,
  input  logic dret_i,

  output logic irq_ack_o,
  output logic count_en_o,
  output logic core_sleep_o,
  output logic debug_havereset_o,
  output logic debug_running_o,
  output logic debug_halted_o
);

  core_ctrl_pkg::ctrl_state_e state_q;
  core_ctrl_pkg::ctrl_state_e state_d;

  // Sticky fetch enable
  logic fetch_enable_q;
  logic fetch_enable;
  // Set by reset, cleared once boot completes
  logic havereset_q;

  //////////////////////////////////////////////////////////////////////
  // Fetch enable and havereset
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fetch_enable_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_enable_q <= 1'b1;
    end
  end

  assign fetch_enable = fetch_enable_i | fetch_enable_q;

  // Drops together with the move to FUNCTIONAL
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      havereset_q <= 1'b1;
    end else if (state_q == core_ctrl_pkg::BOOT_SET) begin
      havereset_q <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Next state and acknowledge
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    irq_ack_o = 1'b0;
    case (state_q)
      core_ctrl_pkg::RESET: begin
        if (fetch_enable) begin
          state_d = core_ctrl_pkg::BOOT_SET;
        end
      end
      core_ctrl_pkg::BOOT_SET: begin
        state_d = core_ctrl_pkg::FUNCTIONAL;
      end
      core_ctrl_pkg::FUNCTIONAL: begin
        // Debug beats interrupts, interrupts beat wfi
        if (debug_req_i) begin
          state_d = core_ctrl_pkg::DEBUG_HALTED;
        end else if (irq_req_i) begin
          irq_ack_o = 1'b1;
        end else if (wfi_i) begin
          state_d = core_ctrl_pkg::SLEEP;
        end
      end
      core_ctrl_pkg::SLEEP: begin
        // Wake-up does not need the global enable
        if (debug_req_i) begin
          state_d = core_ctrl_pkg::DEBUG_HALTED;
        end else if (irq_wu_i) begin
          state_d = core_ctrl_pkg::FUNCTIONAL;
        end
      end
      core_ctrl_pkg::DEBUG_HALTED: begin
        if (dret_i) begin
          state_d = core_ctrl_pkg::FUNCTIONAL;
        end
      end
      default: begin
        state_d = core_ctrl_pkg::RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= core_ctrl_pkg::RESET;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Status outputs
  //////////////////////////////////////////////////////////////////////

  // Counting only while running code
  assign count_en_o        = (state_q == core_ctrl_pkg::FUNCTIONAL);
  assign core_sleep_o      = (state_q == core_ctrl_pkg::SLEEP);
  assign debug_halted_o    = (state_q == core_ctrl_pkg::DEBUG_HALTED);
  assign debug_running_o   = (state_q == core_ctrl_pkg::FUNCTIONAL) ||
                             (state_q == core_ctrl_pkg::SLEEP);
  assign debug_havereset_o = havereset_q;

  // MIE clear in the CSRs must drop the request after one ack
  a_ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
    irq_ack_o |=> !irq_ack_o);

endmodule

//--- source/core_csr_pkg.sv
// CSR addresses, CSR operation codes, mstatus bit positions and CSR data width
package core_csr_pkg;

  //////////////////////////////////////////////////////////////////////
  // CSR address map
  //////////////////////////////////////////////////////////////////////

  // Standard machine-mode addresses
  typedef enum logic [11:0] {
    CSR_MSTATUS = 12'h300,
    CSR_MIE     = 12'h304,
    CSR_MCAUSE  = 12'h342,
    // Low word of the cycle counter
    CSR_MCYCLE  = 12'hB00
  } csr_addr_e;

  //////////////////////////////////////////////////////////////////////
  // CSR operations
  //////////////////////////////////////////////////////////////////////

  // Write, set bits, clear bits
  typedef enum logic [1:0] {
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // Global interrupt enable and its saved copy
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;

  // Data width of every CSR
  localparam int CSR_DATA_W = 32;

endpackage

//--- source/core_ctrl.sv
// Top level of the control slice with interrupt controller, CSRs, FSM and cycle counter
`timescale 1ns/10ps

module core_ctrl #(
  parameter int MCYCLE_WIDTH = 64
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                fetch_enable_i,

  // Interrupts, debug and pipeline events
  input  logic [core_ctrl_pkg::IRQ_NUM-1:0]   irq_i,
  input  logic                                debug_req_i,
  input  logic                                wfi_i,
  input  logic                                mret_i,
  input  logic                                dret_i,

  // CSR port
  input  logic                                csr_we_i,
  input  core_csr_pkg::csr_addr_e             csr_addr_i,
  input  core_csr_pkg::csr_op_e               csr_op_i,
  input  logic [core_csr_pkg::CSR_DATA_W-1:0] csr_wdata_i,
  input  core_csr_pkg::csr_addr_e             csr_raddr_i,
  output logic [core_csr_pkg::CSR_DATA_W-1:0] csr_rdata_o,

  output logic                                irq_ack_o,
  output logic [core_ctrl_pkg::IRQ_ID_W-1:0]  irq_id_o,
  output logic [MCYCLE_WIDTH-1:0]             mcycle_o,
  output logic                                core_sleep_o,
  output logic                                debug_havereset_o,
  output logic                                debug_running_o,
  output logic                                debug_halted_o
);

  logic                                irq_req;
  logic                                irq_wu;
  logic                                count_en;
  logic [core_ctrl_pkg::IRQ_NUM-1:0]   mie;
  logic                                m_irq_enable;
  logic                                mcycle_we;
  logic [core_csr_pkg::CSR_DATA_W-1:0] mcycle_wdata;

  //////////////////////////////////////////////////////////////////////
  // Interrupt controller
  //////////////////////////////////////////////////////////////////////

  int_controller int_controller_i (
    .clk_i          ( clk_i        ),
    .rst_i          ( rst_i        ),
    .irq_i          ( irq_i        ),
    .mie_i          ( mie          ),
    .m_irq_enable_i ( m_irq_enable ),
    .irq_req_o      ( irq_req      ),
    .irq_wu_o       ( irq_wu       ),
    .irq_id_o       ( irq_id_o     )
  );

  //////////////////////////////////////////////////////////////////////
  // CSRs
  //////////////////////////////////////////////////////////////////////

  cs_registers cs_registers_i (
    .clk_i          ( clk_i                                     ),
    .rst_i          ( rst_i                                     ),
    .csr_we_i       ( csr_we_i                                  ),
    .csr_addr_i     ( csr_addr_i                                ),
    .csr_op_i       ( csr_op_i                                  ),
    .csr_wdata_i    ( csr_wdata_i                               ),
    .csr_raddr_i    ( csr_raddr_i                               ),
    .csr_rdata_o    ( csr_rdata_o                               ),
    .irq_ack_i      ( irq_ack_o                                 ),
    .irq_id_i       ( irq_id_o                                  ),
    .mret_i         ( mret_i                                    ),
    // Only the low word is readable
    .mcycle_i       ( mcycle_o[core_csr_pkg::CSR_DATA_W-1:0]    ),
    .mie_o          ( mie                                       ),
    .m_irq_enable_o ( m_irq_enable                              ),
    .mcycle_we_o    ( mcycle_we                                 ),
    .mcycle_wdata_o ( mcycle_wdata                              )
  );

  //////////////////////////////////////////////////////////////////////
  // Controller FSM and cycle counter
  //////////////////////////////////////////////////////////////////////

  controller_fsm controller_fsm_i (
    .clk_i             ( clk_i             ),
    .rst_i             ( rst_i             ),
    .fetch_enable_i    ( fetch_enable_i    ),
    .irq_req_i         ( irq_req           ),
    .irq_wu_i          ( irq_wu            ),
    .debug_req_i       ( debug_req_i       ),
    .wfi_i             ( wfi_i             ),
    .dret_i            ( dret_i            ),
    .irq_ack_o         ( irq_ack_o         ),
    .count_en_o        ( count_en          ),
    .core_sleep_o      ( core_sleep_o      ),
    .debug_havereset_o ( debug_havereset_o ),
    .debug_running_o   ( debug_running_o   ),
    .debug_halted_o    ( debug_halted_o    )
  );

  cycle_counter #(
    .MCYCLE_WIDTH ( MCYCLE_WIDTH )
  ) cycle_counter_i (
    .clk_i       ( clk_i        ),
    .rst_i       ( rst_i        ),
    .count_en_i  ( count_en     ),
    .load_i      ( mcycle_we    ),
    .load_data_i ( mcycle_wdata ),
    .mcycle_o    ( mcycle_o     )
  );

endmodule

//--- source/core_ctrl_pkg.sv
// Controller state encoding, interrupt line count, interrupt id width and mcause flag
package core_ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // Controller states
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    // Waiting for fetch enable
    RESET        = 3'd0,
    // One cycle of boot setup
    BOOT_SET     = 3'd1,
    // Normal running
    FUNCTIONAL   = 3'd2,
    // Stopped after wfi, waiting for wake-up
    SLEEP        = 3'd3,
    // Halted in debug mode
    DEBUG_HALTED = 3'd4
  } ctrl_state_e;

  //////////////////////////////////////////////////////////////////////
  // Interrupts
  //////////////////////////////////////////////////////////////////////

  // Number of interrupt lines
  localparam int IRQ_NUM = 32;

  // Width of an interrupt id
  localparam int IRQ_ID_W = 5;

  // Interrupt flag position in mcause
  localparam int MCAUSE_IRQ_BIT = 31;

endpackage

//--- source/cs_registers.sv
// Machine CSRs mstatus, mie and mcause with read/write port, trap and mret updates
`timescale 1ns/10ps

module cs_registers (
  input  logic                                clk_i,
  input  logic                                rst_i,

  // Software CSR access
  input  logic                                csr_we_i,
  input  core_csr_pkg::csr_addr_e             csr_addr_i,
  input  core_csr_pkg::csr_op_e               csr_op_i,
  input  logic [core_csr_pkg::CSR_DATA_W-1:0] csr_wdata_i,
  input  core_csr_pkg::csr_addr_e             csr_raddr_i,
  output logic [core_csr_pkg::CSR_DATA_W-1:0] csr_rdata_o,

  // Trap and return events
  input  logic                                irq_ack_i,
  input  logic [core_ctrl_pkg::IRQ_ID_W-1:0]  irq_id_i,
  input  logic                                mret_i,

  // Counter low word in, load out
  input  logic [core_csr_pkg::CSR_DATA_W-1:0] mcycle_i,
  output logic [core_ctrl_pkg::IRQ_NUM-1:0]   mie_o,
  output logic                                m_irq_enable_o,
  output logic                                mcycle_we_o,
  output logic [core_csr_pkg::CSR_DATA_W-1:0] mcycle_wdata_o
);

  localparam int DW = core_csr_pkg::CSR_DATA_W;

  logic                              mstatus_mie_q;
  logic                              mstatus_mpie_q;
  logic [core_ctrl_pkg::IRQ_NUM-1:0] mie_q;
  logic [DW-1:0]                     mcause_q;

  // Read views and post-operation write values
  logic [DW-1:0] mstatus_rdata;
  logic [DW-1:0] mstatus_wdata;
  logic [DW-1:0] mie_wdata;
  logic [DW-1:0] mcause_wdata;
  logic [DW-1:0] trap_cause;

  // Per-register write strobes
  logic we_mstatus;
  logic we_mie;
  logic we_mcause;

  // Write, set or clear against the old value
  function automatic logic [DW-1:0] csr_apply(input core_csr_pkg::csr_op_e op,
                                              input logic [DW-1:0] old_val,
                                              input logic [DW-1:0] wdata);
    case (op)
      core_csr_pkg::CSR_OP_WRITE: return wdata;
      core_csr_pkg::CSR_OP_SET:   return old_val | wdata;
      core_csr_pkg::CSR_OP_CLEAR: return old_val & ~wdata;
      default:                    return old_val;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Write decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_rdata = '0;
    mstatus_rdata[core_csr_pkg::MSTATUS_MIE_BIT]  = mstatus_mie_q;
    mstatus_rdata[core_csr_pkg::MSTATUS_MPIE_BIT] = mstatus_mpie_q;
  end

  // Cause word of a taken interrupt
  always_comb begin
    trap_cause = '0;
    trap_cause[core_ctrl_pkg::MCAUSE_IRQ_BIT]  = 1'b1;
    trap_cause[core_ctrl_pkg::IRQ_ID_W-1:0]    = irq_id_i;
  end

  assign we_mstatus  = csr_we_i && (csr_addr_i == core_csr_pkg::CSR_MSTATUS);
  assign we_mie      = csr_we_i && (csr_addr_i == core_csr_pkg::CSR_MIE);
  assign we_mcause   = csr_we_i && (csr_addr_i == core_csr_pkg::CSR_MCAUSE);
  assign mcycle_we_o = csr_we_i && (csr_addr_i == core_csr_pkg::CSR_MCYCLE);

  assign mstatus_wdata  = csr_apply(csr_op_i, mstatus_rdata, csr_wdata_i);
  assign mie_wdata      = csr_apply(csr_op_i, mie_q, csr_wdata_i);
  assign mcause_wdata   = csr_apply(csr_op_i, mcause_q, csr_wdata_i);
  // Counter owns the register, only the new low word is formed here
  assign mcycle_wdata_o = csr_apply(csr_op_i, mcycle_i, csr_wdata_i);

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  // Trap first, then mret, then software
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
    end else if (irq_ack_i) begin
      mstatus_mpie_q <= mstatus_mie_q;
      mstatus_mie_q  <= 1'b0;
    end else if (mret_i) begin
      mstatus_mie_q  <= mstatus_mpie_q;
      mstatus_mpie_q <= 1'b1;
    end else if (we_mstatus) begin
      mstatus_mie_q  <= mstatus_wdata[core_csr_pkg::MSTATUS_MIE_BIT];
      mstatus_mpie_q <= mstatus_wdata[core_csr_pkg::MSTATUS_MPIE_BIT];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mie_q <= '0;
    end else if (we_mie) begin
      mie_q <= mie_wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mcause_q <= '0;
    end else if (irq_ack_i) begin
      mcause_q <= trap_cause;
    end else if (we_mcause) begin
      mcause_q <= mcause_wdata;
    end
  end

  assign mie_o          = mie_q;
  assign m_irq_enable_o = mstatus_mie_q;

  // Combinational read port
  always_comb begin
    case (csr_raddr_i)
      core_csr_pkg::CSR_MSTATUS: csr_rdata_o = mstatus_rdata;
      core_csr_pkg::CSR_MIE:     csr_rdata_o = mie_q;
      core_csr_pkg::CSR_MCAUSE:  csr_rdata_o = mcause_q;
      core_csr_pkg::CSR_MCYCLE:  csr_rdata_o = mcycle_i;
      default:                   csr_rdata_o = '0;
    endcase
  end

  // Controller never acknowledges on an mret cycle
  a_ack_mret_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(irq_ack_i && mret_i));

endmodule

//--- source/cycle_counter.sv
// Wide cycle counter with count enable and a low-word load
`timescale 1ns/10ps

module cycle_counter #(
  parameter int MCYCLE_WIDTH = 64
) (
  input  logic                                clk_i,
  input  logic                                rst_i,

  input  logic                                count_en_i,

  // CSR write of the low word
  input  logic                                load_i,
  input  logic [core_csr_pkg::CSR_DATA_W-1:0] load_data_i,

  output logic [MCYCLE_WIDTH-1:0]             mcycle_o
);

  // Bits replaced by a load
  localparam logic [MCYCLE_WIDTH-1:0] LOW_MASK =
    MCYCLE_WIDTH'({core_csr_pkg::CSR_DATA_W{1'b1}});

  logic [MCYCLE_WIDTH-1:0] mcycle_q;

  // Load wins over counting, upper bits kept
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mcycle_q <= '0;
    end else if (load_i) begin
      mcycle_q <= (mcycle_q & ~LOW_MASK) | MCYCLE_WIDTH'(load_data_i);
    end else if (count_en_i) begin
      mcycle_q <= mcycle_q + 1'b1;
    end
  end

  assign mcycle_o = mcycle_q;

endmodule

//--- source/int_controller.sv
// Interrupt controller with pending register, mie masking, wake-up and priority pick
`timescale 1ns/10ps

module int_controller (
  input  logic                                clk_i,
  input  logic                                rst_i,

  // Raw interrupt lines
  input  logic [core_ctrl_pkg::IRQ_NUM-1:0]   irq_i,

  // From CSRs
  input  logic [core_ctrl_pkg::IRQ_NUM-1:0]   mie_i,
  input  logic                                m_irq_enable_i,

  // To controller FSM
  output logic                                irq_req_o,
  output logic                                irq_wu_o,
  output logic [core_ctrl_pkg::IRQ_ID_W-1:0]  irq_id_o
);

  // Registered lines
  logic [core_ctrl_pkg::IRQ_NUM-1:0] mip_q;
  // Pending and enabled in mie
  logic [core_ctrl_pkg::IRQ_NUM-1:0] irq_masked;

  //////////////////////////////////////////////////////////////////////
  // Pending register
  //////////////////////////////////////////////////////////////////////

  // A line high at an edge is pending from that edge on
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i;
    end
  end

  assign irq_masked = mip_q & mie_i;

  // Wake-up ignores the global enable
  assign irq_wu_o  = |irq_masked;
  assign irq_req_o = irq_wu_o & m_irq_enable_i;

  //////////////////////////////////////////////////////////////////////
  // Priority pick
  //////////////////////////////////////////////////////////////////////

  // Upward scan, last hit wins
  // so the highest-numbered enabled line is chosen
  always_comb begin
    irq_id_o = '0;
    for (int i = 0; i < core_ctrl_pkg::IRQ_NUM; i++) begin
      if (irq_masked[i]) begin
        irq_id_o = core_ctrl_pkg::IRQ_ID_W'(i);
      end
    end
  end

endmodule

//--- verification/core_ctrl_tb.sv
// Testbench for core_ctrl with stimulus, reference model, assertions, watchdog and summary
`timescale 1ns/10ps

module core_ctrl_tb;

  localparam int MCYCLE_WIDTH = 64;
  localparam int CLK_PERIOD   = 100;
  localparam int CSR_OPS      = 30;
  localparam int IRQ_ROUNDS   = 4;
  // Rough cycle budget per test, used by the watchdog
  localparam int TEST_CYCLES  = 10 + (2 * CSR_OPS + 20) + (IRQ_ROUNDS * 14) + 20 + 40 + 40;
  localparam int MARGIN       = 100;
  localparam logic [31:0] MIE_MASK = 32'h1 << core_csr_pkg::MSTATUS_MIE_BIT;
  localparam core_csr_pkg::csr_addr_e ADDR_LIST [4] = '{core_csr_pkg::CSR_MSTATUS,
    core_csr_pkg::CSR_MIE, core_csr_pkg::CSR_MCAUSE, core_csr_pkg::CSR_MCYCLE};

  logic clk, rst, fetch_enable;
  logic [core_ctrl_pkg::IRQ_NUM-1:0] irq;
  logic debug_req, wfi, mret, dret, csr_we;
  core_csr_pkg::csr_addr_e csr_addr, csr_raddr;
  core_csr_pkg::csr_op_e   csr_op;
  logic [31:0] csr_wdata, csr_rdata;
  logic irq_ack, core_sleep, havereset, running, halted;
  logic [core_ctrl_pkg::IRQ_ID_W-1:0] irq_id;
  logic [MCYCLE_WIDTH-1:0] mcycle;
  int errors = 0;
  int cycles = 0;

  core_ctrl #(.MCYCLE_WIDTH(MCYCLE_WIDTH)) i_core_ctrl (
    .clk_i(clk), .rst_i(rst), .fetch_enable_i(fetch_enable), .irq_i(irq),
    .debug_req_i(debug_req), .wfi_i(wfi), .mret_i(mret), .dret_i(dret),
    .csr_we_i(csr_we), .csr_addr_i(csr_addr), .csr_op_i(csr_op), .csr_wdata_i(csr_wdata),
    .csr_raddr_i(csr_raddr), .csr_rdata_o(csr_rdata), .irq_ack_o(irq_ack), .irq_id_o(irq_id),
    .mcycle_o(mcycle), .core_sleep_o(core_sleep), .debug_havereset_o(havereset),
    .debug_running_o(running), .debug_halted_o(halted)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycles <= cycles + 1;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  core_ctrl_pkg::ctrl_state_e m_state;
  logic m_fe, m_havereset, m_mie_bit, m_mpie, m_req, m_wu, m_ack;
  logic [core_ctrl_pkg::IRQ_NUM-1:0] m_mip, m_mie;
  logic [core_ctrl_pkg::IRQ_ID_W-1:0] m_id;
  logic [31:0] m_mcause, m_mstatus, m_rdata;
  logic [MCYCLE_WIDTH-1:0] m_mcycle;

  // Highest-numbered set line, scanning down from the top
  function automatic logic [core_ctrl_pkg::IRQ_ID_W-1:0] highest_line(
    input logic [core_ctrl_pkg::IRQ_NUM-1:0] lines);
    for (int i = core_ctrl_pkg::IRQ_NUM - 1; i >= 0; i--) begin
      if (lines[i]) begin
        return core_ctrl_pkg::IRQ_ID_W'(i);
      end
    end
    return '0;
  endfunction

  function automatic logic [31:0] op_result(input core_csr_pkg::csr_op_e op,
                                            input logic [31:0] cur, input logic [31:0] data);
    if (op == core_csr_pkg::CSR_OP_WRITE) begin
      return data;
    end
    if (op == core_csr_pkg::CSR_OP_SET) begin
      return cur | data;
    end
    return cur & ~data;
  endfunction

  assign m_wu  = |(m_mip & m_mie);
  assign m_req = m_wu && m_mie_bit;
  assign m_id  = highest_line(m_mip & m_mie);
  assign m_ack = (m_state == core_ctrl_pkg::FUNCTIONAL) && !debug_req && m_req;

  always_comb begin
    m_mstatus = '0;
    m_mstatus[core_csr_pkg::MSTATUS_MIE_BIT]  = m_mie_bit;
    m_mstatus[core_csr_pkg::MSTATUS_MPIE_BIT] = m_mpie;
    case (csr_raddr)
      core_csr_pkg::CSR_MSTATUS: m_rdata = m_mstatus;
      core_csr_pkg::CSR_MIE:     m_rdata = m_mie;
      core_csr_pkg::CSR_MCAUSE:  m_rdata = m_mcause;
      default:                   m_rdata = m_mcycle[31:0];
    endcase
  end

  always @(posedge clk) begin : model_update
    logic [31:0] st_new;
    st_new = op_result(csr_op, m_mstatus, csr_wdata);
    if (rst) begin
      m_state <= core_ctrl_pkg::RESET;
      {m_fe, m_mie_bit, m_mpie} <= '0;
      m_havereset <= 1'b1;
      {m_mip, m_mie, m_mcause, m_mcycle} <= '0;
    end else begin
      m_mip <= irq;
      m_fe  <= m_fe | fetch_enable;
      if (m_state == core_ctrl_pkg::BOOT_SET) m_havereset <= 1'b0;
      case (m_state)
        core_ctrl_pkg::RESET: if (fetch_enable || m_fe) m_state <= core_ctrl_pkg::BOOT_SET;
        core_ctrl_pkg::BOOT_SET: m_state <= core_ctrl_pkg::FUNCTIONAL;
        core_ctrl_pkg::FUNCTIONAL: begin
          if (debug_req) m_state <= core_ctrl_pkg::DEBUG_HALTED;
          else if (!m_req && wfi) m_state <= core_ctrl_pkg::SLEEP;
        end
        core_ctrl_pkg::SLEEP: begin
          if (debug_req) m_state <= core_ctrl_pkg::DEBUG_HALTED;
          else if (m_wu) m_state <= core_ctrl_pkg::FUNCTIONAL;
        end
        default: if (dret) m_state <= core_ctrl_pkg::FUNCTIONAL;
      endcase
      // Trap beats mret, mret beats software
      if (m_ack) begin
        m_mpie    <= m_mie_bit;
        m_mie_bit <= 1'b0;
      end else if (mret) begin
        m_mie_bit <= m_mpie;
        m_mpie    <= 1'b1;
      end else if (csr_we && csr_addr == core_csr_pkg::CSR_MSTATUS) begin
        m_mie_bit <= st_new[core_csr_pkg::MSTATUS_MIE_BIT];
        m_mpie    <= st_new[core_csr_pkg::MSTATUS_MPIE_BIT];
      end
      if (csr_we && csr_addr == core_csr_pkg::CSR_MIE) begin
        m_mie <= op_result(csr_op, m_mie, csr_wdata);
      end
      if (m_ack) begin
        m_mcause <= (32'h1 << core_ctrl_pkg::MCAUSE_IRQ_BIT) | 32'(m_id);
      end else if (csr_we && csr_addr == core_csr_pkg::CSR_MCAUSE) begin
        m_mcause <= op_result(csr_op, m_mcause, csr_wdata);
      end
      // Low-word load wins over counting
      if (csr_we && csr_addr == core_csr_pkg::CSR_MCYCLE) begin
        m_mcycle[31:0] <= op_result(csr_op, m_mcycle[31:0], csr_wdata);
      end else if (m_state == core_ctrl_pkg::FUNCTIONAL) begin
        m_mcycle <= m_mcycle + 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic report_fail(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    errors++;
  endtask

  a_ack: assert property (@(posedge clk) disable iff (rst) irq_ack == m_ack)
    else report_fail("irq_ack_o differs from model");
  a_ack_pulse: assert property (@(posedge clk) disable iff (rst) irq_ack |=> !irq_ack)
    else report_fail("irq_ack_o longer than one cycle");
  a_id: assert property (@(posedge clk) disable iff (rst) irq_ack |-> irq_id == m_id)
    else report_fail("irq_id_o is not the highest enabled line");
  a_rdata: assert property (@(posedge clk) disable iff (rst) csr_rdata == m_rdata)
    else report_fail("csr_rdata_o differs from model");
  a_mcause: assert property (@(posedge clk) disable iff (rst)
    ($past(irq_ack) && csr_raddr == core_csr_pkg::CSR_MCAUSE) |->
    csr_rdata == ((32'h1 << core_ctrl_pkg::MCAUSE_IRQ_BIT) | 32'($past(m_id))))
    else report_fail("mcause after acknowledge is wrong");
  a_mie_clr: assert property (@(posedge clk) disable iff (rst)
    ($past(irq_ack) && csr_raddr == core_csr_pkg::CSR_MSTATUS) |->
    !csr_rdata[core_csr_pkg::MSTATUS_MIE_BIT])
    else report_fail("MIE still set after acknowledge");
  a_mcycle: assert property (@(posedge clk) disable iff (rst) mcycle == m_mcycle)
    else report_fail("mcycle_o differs from model");
  a_status: assert property (@(posedge clk) disable iff (rst)
    core_sleep == (m_state == core_ctrl_pkg::SLEEP) &&
    halted == (m_state == core_ctrl_pkg::DEBUG_HALTED) && havereset == m_havereset &&
    running == (m_state == core_ctrl_pkg::FUNCTIONAL || m_state == core_ctrl_pkg::SLEEP))
    else report_fail("status outputs differ from model");
  a_boot_hold: assert property (@(posedge clk) disable iff (rst)
    ($past(m_state) == core_ctrl_pkg::RESET && $past(fetch_enable)) |-> !running && havereset)
    else report_fail("running one cycle after fetch enable");
  a_boot_run: assert property (@(posedge clk) disable iff (rst)
    ($past(m_state, 2) == core_ctrl_pkg::RESET && $past(fetch_enable, 2)) |->
    running && !havereset)
    else report_fail("running not up two cycles after fetch enable");
  a_wfi: assert property (@(posedge clk) disable iff (rst)
    (wfi && running && !core_sleep && !debug_req && !irq_ack) |=> core_sleep)
    else report_fail("no sleep after wfi");
  a_sleep_hold: assert property (@(posedge clk) disable iff (rst)
    (core_sleep && !csr_we) |=> $stable(mcycle))
    else report_fail("mcycle_o moved while sleeping");
  a_wake: assert property (@(posedge clk) disable iff (rst)
    (core_sleep && !debug_req && |(m_mip & m_mie)) |=> running && !core_sleep)
    else report_fail("enabled line did not wake the core");
  a_debug: assert property (@(posedge clk) disable iff (rst) (debug_req && running) |=> halted)
    else report_fail("no halt after debug request");
  a_halt_hold: assert property (@(posedge clk) disable iff (rst)
    (halted && !csr_we) |=> $stable(mcycle))
    else report_fail("mcycle_o moved while halted");
  a_halt_no_ack: assert property (@(posedge clk) disable iff (rst) halted |-> !irq_ack)
    else report_fail("acknowledge while halted");
  a_dret: assert property (@(posedge clk) disable iff (rst)
    (dret && halted) |=> running && !halted)
    else report_fail("dret did not resume");

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic csr_write(input core_csr_pkg::csr_addr_e addr, input core_csr_pkg::csr_op_e op,
                           input logic [31:0] data);
    csr_we    = 1'b1;
    csr_addr  = addr;
    csr_op    = op;
    csr_wdata = data;
    next_cycle();
    csr_we = 1'b0;
  endtask

  task automatic wait_until_awake(input int max_cycles);
    int n;
    n = 0;
    while (core_sleep && n < max_cycles) begin
      next_cycle();
      n++;
    end
    if (core_sleep) begin
      $display("Core did not leave sleep within %0d cycles at %0t", max_cycles, $time);
      errors++;
    end
  endtask

  task automatic pulse_wfi();
    wfi = 1'b1;
    next_cycle();
    wfi = 1'b0;
  endtask

  task automatic pulse_debug_req();
    debug_req = 1'b1;
    next_cycle();
    debug_req = 1'b0;
  endtask

  task automatic pulse_dret();
    dret = 1'b1;
    next_cycle();
    dret = 1'b0;
  endtask

  initial begin : watchdog
    #((4 + TEST_CYCLES + MARGIN) * CLK_PERIOD);
    $display("Timeout: the tests did not finish in the expected time");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin : main
    int k;
    logic [31:0] mask;
    void'($urandom(32'h586fd89c));
    {rst, fetch_enable, debug_req, wfi, mret, dret, csr_we} = 7'b1000000;
    irq       = '0;
    csr_addr  = core_csr_pkg::CSR_MSTATUS;
    csr_raddr = core_csr_pkg::CSR_MSTATUS;
    csr_op    = core_csr_pkg::CSR_OP_WRITE;
    csr_wdata = '0;
    repeat (4) @(posedge clk);
    #5 rst = 1'b0;
    assert (havereset && !running && !halted && !core_sleep && !irq_ack)
      else report_fail("outputs wrong after reset");

    // Boot
    next_cycle();
    fetch_enable = 1'b1;
    next_cycle();
    fetch_enable = 1'b0;
    repeat (4) next_cycle();

    // Random CSR traffic, then a low-word load that carries into the upper word
    for (int i = 0; i < CSR_OPS; i++) begin
      k = $urandom % 4;
      csr_raddr = ADDR_LIST[$urandom % 4];
      csr_write(ADDR_LIST[k], core_csr_pkg::csr_op_e'(($urandom % 3) + 1), $urandom);
      csr_raddr = ADDR_LIST[k];
      next_cycle();
    end
    csr_write(core_csr_pkg::CSR_MSTATUS, core_csr_pkg::CSR_OP_WRITE, '0);
    csr_write(core_csr_pkg::CSR_MIE, core_csr_pkg::CSR_OP_WRITE, '0);
    csr_raddr = core_csr_pkg::CSR_MCYCLE;
    csr_write(core_csr_pkg::CSR_MCYCLE, core_csr_pkg::CSR_OP_WRITE, 32'hFFFF_FFF8);
    repeat (12) next_cycle();

    // Interrupts taken and returned from
    for (int r = 0; r < IRQ_ROUNDS; r++) begin
      k    = $urandom % core_ctrl_pkg::IRQ_NUM;
      mask = $urandom | (32'h1 << k);
      csr_write(core_csr_pkg::CSR_MIE, core_csr_pkg::CSR_OP_WRITE, mask);
      csr_write(core_csr_pkg::CSR_MSTATUS, core_csr_pkg::CSR_OP_SET, MIE_MASK);
      csr_raddr = (r % 2) ? core_csr_pkg::CSR_MSTATUS : core_csr_pkg::CSR_MCAUSE;
      irq = $urandom | (32'h1 << k);
      repeat (3) next_cycle();
      irq = '0;
      repeat (2) next_cycle();
      mret = 1'b1;
      next_cycle();
      mret = 1'b0;
      next_cycle();
    end

    // Masking by mie, then by MIE
    csr_write(core_csr_pkg::CSR_MIE, core_csr_pkg::CSR_OP_WRITE, 32'h0000_00F0);
    irq = 32'hFFFF_FF0F;
    repeat (4) next_cycle();
    csr_write(core_csr_pkg::CSR_MSTATUS, core_csr_pkg::CSR_OP_CLEAR, MIE_MASK);
    irq = 32'h0000_00F0;
    repeat (4) next_cycle();
    irq = '0;
    repeat (2) next_cycle();

    // Sleep and wake, first with MIE clear, then with MIE set
    k = $urandom % core_ctrl_pkg::IRQ_NUM;
    csr_write(core_csr_pkg::CSR_MIE, core_csr_pkg::CSR_OP_WRITE, 32'h1 << k);
    csr_raddr = core_csr_pkg::CSR_MCAUSE;
    for (int s = 0; s < 2; s++) begin
      pulse_wfi();
      repeat (3) next_cycle();
      irq = 32'h1 << k;
      wait_until_awake(5);
      repeat (3) next_cycle();
      irq = '0;
      repeat (2) next_cycle();
      if (s == 0) begin
        csr_write(core_csr_pkg::CSR_MSTATUS, core_csr_pkg::CSR_OP_SET, MIE_MASK);
      end
    end
    mret = 1'b1;
    next_cycle();
    mret = 1'b0;

    // Debug halt from FUNCTIONAL with a pending line, then from SLEEP
    pulse_debug_req();
    irq = 32'h1 << k;
    repeat (4) next_cycle();
    irq = '0;
    repeat (2) next_cycle();
    pulse_dret();
    repeat (3) next_cycle();
    pulse_wfi();
    repeat (2) next_cycle();
    pulse_debug_req();
    repeat (3) next_cycle();
    pulse_dret();
    repeat (4) next_cycle();

    $display("Summary: %0d errors in %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
